/* build.f */
+incdir+include
hdl/ahb_cache_pkg.sv
hdl/ahb_addr_phase.sv
hdl/cache_tag_store.sv
hdl/cache_data_store.sv
hdl/refill_master.sv
hdl/ahb_read_cache.sv
test/ahb_mem_model.sv
test/tb_ahb_read_cache.sv

/* Makefile */
TOP = tb_ahb_read_cache

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/testdata_cache.txt */
# op addr wdata rdata count: R read, H hit read, P pipelined hit read, W write, X reset.
# rdata is the expected read word, count the downstream bursts after the operation.
R 00001008 00000000 c0de1008 1
H 00001000 00000000 c0de1000 1
H 00001004 00000000 c0de1004 1
H 0000100c 00000000 c0de100c 1
R 00002004 00000000 c0de2004 2
R 00001008 00000000 c0de1008 3
W 0000100c deadbeef 00000000 4
H 0000100c 00000000 deadbeef 4
W 00003010 a5a55a5a 00000000 5
R 00003010 00000000 a5a55a5a 6
H 00003014 00000000 c0de3014 6
H 00003018 00000000 c0de3018 6
P 0000301c 00000000 c0de301c 6
P 00003010 00000000 a5a55a5a 6
P 00003014 00000000 c0de3014 6
P 00001004 00000000 c0de1004 6
X 00000000 00000000 00000000 6
R 00001004 00000000 c0de1004 7
R 00003018 00000000 c0de3018 8
H 0000100c 00000000 deadbeef 8

/* test/tb_ahb_read_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_read_cache;

    localparam int TIMEOUT = 64;

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] count;
    } op_t;

    logic                     upstream_intf;
    logic                     rst;
    ahb_cache_pkg::ahb_req_t  up_req;
    ahb_cache_pkg::ahb_resp_t up_resp;
    ahb_cache_pkg::ahb_req_t  dn_req;
    ahb_cache_pkg::ahb_resp_t dn_resp;
    int unsigned              bursts;
    int                       fd;

    ahb_read_cache ahb_read_cache_i (
        .upstream_intf (upstream_intf),
        .rst           (rst),
        .up_req        (up_req),
        .up_resp       (up_resp),
        .dn_req        (dn_req),
        .dn_resp       (dn_resp)
    );

    ahb_mem_model ahb_mem_model_i (
        .upstream_intf (upstream_intf),
        .rst           (rst),
        .dn_req        (dn_req),
        .dn_resp       (dn_resp),
        .bursts        (bursts)
    );

    initial begin
        upstream_intf = 1'b0;
        forever #2 upstream_intf = ~upstream_intf;
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic abort(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) abort($sformatf("ERROR %s: expected %08h, actual %08h", name, exp, act));
    endtask

    task automatic check_resp(input string name, input ahb_cache_pkg::ahb_resp_t exp,
                              input ahb_cache_pkg::ahb_resp_t act);
        if (act !== exp) begin
            abort($sformatf("ERROR %s: expected %08h/%b/%b, actual %08h/%b/%b", name,
                            exp.hrdata, exp.hready, exp.hresp, act.hrdata, act.hready, act.hresp));
        end
    endtask

    task automatic check_count(input string name, input int unsigned exp, input int unsigned act);
        if (act != exp) abort($sformatf("ERROR %s: expected count %0d, actual %0d", name, exp, act));
    endtask

    // ------------------------------
    // Bus helpers
    // ------------------------------
    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge upstream_intf);
        while (up_resp.hready !== 1'b1) begin
            cycles++;
            if (cycles > TIMEOUT) abort($sformatf("%s: hready stayed low for too long", name));
            @(negedge upstream_intf);
        end
    endtask

    task automatic drive_addr(input op_t o);
        up_req.haddr  <= o.addr;
        up_req.htrans <= ahb_cache_pkg::HTRANS_NONSEQ;
        up_req.hwrite <= (o.op == "W");
    endtask

    task automatic read_op(output logic ok, output op_t o);
        string line;
        int    n;
        ok = 1'b0;
        o  = '0;
        while (!ok && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %d", o.op, o.addr, o.wdata, o.rdata, o.count);
                if (n != 5) abort($sformatf("the data file has a malformed line: %s", line));
                ok = 1'b1;
            end
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        op_t                      cur;
        op_t                      nxt;
        logic                     ok;
        logic                     placed;
        string                    name;
        ahb_cache_pkg::ahb_resp_t exp_resp;
        rst           = 1'b1;
        up_req        = '0;
        up_req.hsize  = ahb_cache_pkg::HSIZE_WORD;
        up_req.hburst = ahb_cache_pkg::HBURST_SINGLE;
        fd = $fopen("test/testdata_cache.txt", "r");
        if (fd == 0) abort("could not open test/testdata_cache.txt");
        repeat (3) @(posedge upstream_intf);
        rst    <= 1'b0;
        placed = 1'b0;
        read_op(ok, cur);
        while (ok) begin
            name = $sformatf("%c %08h", cur.op, cur.addr);
            if (cur.op == "X") begin
                @(posedge upstream_intf);
                rst <= 1'b1;
                repeat (3) @(posedge upstream_intf);
                rst <= 1'b0;
                read_op(ok, cur);
            end else begin
                if (!placed) begin
                    @(posedge upstream_intf);
                    drive_addr(cur);
                    wait_ready(name);
                end
                read_op(ok, nxt);
                @(posedge upstream_intf);  // Address of cur is taken here.
                up_req.hwdata <= cur.wdata;
                placed = ok && (nxt.op == "P");
                if (placed) begin
                    drive_addr(nxt);  // Overlaps the data phase of cur.
                end else begin
                    up_req.htrans <= ahb_cache_pkg::HTRANS_IDLE;
                    up_req.hwrite <= 1'b0;
                end
                if (cur.op == "H" || cur.op == "P") begin
                    // A hit has no wait state, so the first data cycle must be ready.
                    @(negedge upstream_intf);
                    exp_resp.hrdata = cur.rdata;
                    exp_resp.hready = 1'b1;
                    exp_resp.hresp  = ahb_cache_pkg::HRESP_OKAY;
                    check_resp(name, exp_resp, up_resp);
                end else begin
                    wait_ready(name);
                    if (cur.op != "W") check_rdata(name, cur.rdata, up_resp.hrdata);
                end
                check_count(name, cur.count, bursts);
                cur = nxt;
            end
        end
        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/ahb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_model (
    input  wire                           upstream_intf,
    input  wire                           rst,
    input  wire ahb_cache_pkg::ahb_req_t  dn_req,
    output ahb_cache_pkg::ahb_resp_t      dn_resp,
    output int unsigned                   bursts
);

    logic [31:0] mem [logic [31:0]];  // Holds only the words that were written.
    logic [31:0] lfsr = 32'h06fa_8aa4;
    int unsigned burst_cnt = 0;
    logic        dp_valid;
    logic        dp_write;
    logic [31:0] dp_addr;
    logic [1:0]  wait_cnt;
    logic [31:0] rdata_q;
    logic        take;

    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'hc0de_0000;
    endfunction

    assign take = (dn_req.htrans == ahb_cache_pkg::HTRANS_NONSEQ) ||
                  (dn_req.htrans == ahb_cache_pkg::HTRANS_SEQ);

    assign dn_resp.hready = !dp_valid || (wait_cnt == 2'd0);
    assign dn_resp.hrdata = rdata_q;
    assign dn_resp.hresp  = ahb_cache_pkg::HRESP_OKAY;
    assign bursts         = burst_cnt;

    // ------------------------------
    // Slave pipeline
    // ------------------------------
    always @(posedge upstream_intf) begin
        logic [31:0] l1;
        logic [31:0] l2;
        l1 = lfsr_step(lfsr);
        l2 = lfsr_step(l1);
        if (rst) begin
            dp_valid <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (!dn_resp.hready) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            if (dp_valid && dp_write) begin
                mem[dp_addr] = dn_req.hwdata;  // Visible to a read taken at this edge.
            end
            dp_valid <= take;
            if (take) begin
                dp_addr  <= dn_req.haddr;
                dp_write <= dn_req.hwrite;
                rdata_q  <= read_word(dn_req.haddr);
                wait_cnt <= {l1[0], l2[0]};  // Two bits per beat, one step each.
                lfsr     <= l2;
                if (dn_req.htrans == ahb_cache_pkg::HTRANS_NONSEQ) begin
                    burst_cnt <= burst_cnt + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ahb_read_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_read_cache (
    input  wire                           upstream_intf,
    input  wire                           rst,
    input  wire ahb_cache_pkg::ahb_req_t  up_req,
    output ahb_cache_pkg::ahb_resp_t      up_resp,
    output ahb_cache_pkg::ahb_req_t       dn_req,
    input  wire ahb_cache_pkg::ahb_resp_t dn_resp
);

    ahb_cache_pkg::pend_t pend;

    logic        accept;
    logic        hit;
    logic        tag_set;
    logic        fill_we;
    logic [1:0]  fill_word;
    logic [31:0] fill_data;
    logic [31:0] rd_word;

    // ------------------------------
    // Upstream address capture
    // ------------------------------
    ahb_addr_phase ahb_addr_phase_i (
        .upstream_intf (upstream_intf),
        .rst           (rst),
        .up_req        (up_req),
        .accept        (accept),
        .pend          (pend)
    );

    // ------------------------------
    // Tag and data arrays
    // ------------------------------
    cache_tag_store cache_tag_store_i (
        .upstream_intf (upstream_intf),
        .rst           (rst),
        .pend          (pend),
        .tag_set       (tag_set),
        .hit           (hit)
    );

    cache_data_store cache_data_store_i (
        .upstream_intf (upstream_intf),
        .rst           (rst),
        .pend          (pend),
        .fill_we       (fill_we),
        .fill_word     (fill_word),
        .fill_data     (fill_data),
        .rd_word       (rd_word)
    );

    // ------------------------------
    // Downstream master
    // ------------------------------
    refill_master refill_master_i (
        .upstream_intf (upstream_intf),
        .rst           (rst),
        .pend          (pend),
        .hit           (hit),
        .up_hwdata     (up_req.hwdata),  // Write data belongs to the data phase.
        .dn_req        (dn_req),
        .dn_resp       (dn_resp),
        .rd_word       (rd_word),
        .tag_set       (tag_set),
        .fill_we       (fill_we),
        .fill_word     (fill_word),
        .fill_data     (fill_data),
        .up_resp       (up_resp),
        .accept        (accept)
    );

endmodule

`default_nettype wire

/* hdl/refill_master.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_master (
    input  wire                          upstream_intf,
    input  wire                          rst,
    input  wire ahb_cache_pkg::pend_t    pend,
    input  wire                          hit,
    input  wire [31:0]                   up_hwdata,
    output ahb_cache_pkg::ahb_req_t      dn_req,
    input  wire ahb_cache_pkg::ahb_resp_t dn_resp,
    input  wire [31:0]                   rd_word,
    output logic                         tag_set,
    output logic                         fill_we,
    output logic [1:0]                   fill_word,
    output logic [31:0]                  fill_data,
    output ahb_cache_pkg::ahb_resp_t     up_resp,
    output logic                         accept
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_BADDR,
        S_BDATA,
        S_WADDR,
        S_WDATA,
        S_DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic [1:0] beat_q;  // Data beat of the burst, counted from the critical word.

    logic miss;
    logic wr_req;
    logic beat_done;
    logic wr_done;
    logic up_ready;
    logic [1:0] crit;
    logic [1:0] addr_word;
    ahb_cache_pkg::cache_addr_t dn_addr;

    assign crit   = pend.addr.f.word_off;
    assign miss   = pend.valid && !pend.write && !hit;
    assign wr_req = pend.valid && pend.write;

    assign beat_done = (state_q == S_BDATA) && dn_resp.hready;
    assign wr_done   = (state_q == S_WDATA) && dn_resp.hready;

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (wr_req) begin
                    state_d = S_WADDR;
                end else if (miss) begin
                    state_d = S_BADDR;
                end
            end
            S_BADDR: if (dn_resp.hready) state_d = S_BDATA;
            S_BDATA: if (beat_done && beat_q == 2'd3) state_d = S_DONE;
            S_WADDR: if (dn_resp.hready) state_d = S_WDATA;
            S_WDATA: if (dn_resp.hready) state_d = S_IDLE;
            S_DONE:  state_d = S_IDLE;  // Upstream gets its word in this cycle.
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge upstream_intf) begin
        if (rst) begin
            state_q <= S_IDLE;
            beat_q  <= 2'd0;
        end else begin
            state_q <= state_d;
            if (beat_done) begin
                beat_q <= beat_q + 2'd1;  // Wraps back to zero after the last beat.
            end
        end
    end

    // ------------------------------
    // Downstream request
    // ------------------------------
    // The address phase of beat n+1 overlaps the data phase of beat n.
    assign addr_word = (state_q == S_BDATA) ? crit + beat_q + 2'd1 : crit;

    always_comb begin
        dn_addr            = pend.addr;
        dn_addr.f.word_off = addr_word;
        dn_addr.f.byte_off = 2'b00;

        dn_req.haddr  = dn_addr.raw;
        dn_req.htrans = ahb_cache_pkg::HTRANS_IDLE;
        if (state_q == S_BADDR || state_q == S_WADDR) begin
            dn_req.htrans = ahb_cache_pkg::HTRANS_NONSEQ;
        end else if (state_q == S_BDATA && beat_q != 2'd3) begin
            dn_req.htrans = ahb_cache_pkg::HTRANS_SEQ;
        end
        dn_req.hwrite = (state_q == S_WADDR);
        dn_req.hsize  = ahb_cache_pkg::HSIZE_WORD;
        dn_req.hburst = (state_q == S_BADDR || state_q == S_BDATA) ?
                        ahb_cache_pkg::HBURST_WRAP4 : ahb_cache_pkg::HBURST_SINGLE;
        dn_req.hwdata = (state_q == S_WDATA) ? up_hwdata : 32'h0;
    end

    // ------------------------------
    // Line fill and upstream response
    // ------------------------------
    assign fill_we   = beat_done || (wr_done && hit);  // Write hits keep the line coherent.
    assign fill_word = beat_done ? crit + beat_q : crit;
    assign fill_data = beat_done ? dn_resp.hrdata : up_hwdata;
    assign tag_set   = beat_done && (beat_q == 2'd3);

    assign up_ready = (state_q == S_IDLE && !miss && !wr_req) ||
                      (state_q == S_DONE) || wr_done;

    assign up_resp.hrdata = rd_word;
    assign up_resp.hready = up_ready;
    assign up_resp.hresp  = ahb_cache_pkg::HRESP_OKAY;
    assign accept         = up_ready;

    a_seq_is_wrap4: assert property (
        @(posedge upstream_intf) disable iff (rst)
        (dn_req.htrans == ahb_cache_pkg::HTRANS_SEQ) |->
            (dn_req.hburst == ahb_cache_pkg::HBURST_WRAP4)
    ) else $error("SEQ beat outside a WRAP4 burst");

    // A stalled address phase has to be held until the slave takes it.
    a_addr_hold: assert property (
        @(posedge upstream_intf) disable iff (rst)
        (dn_req.htrans != ahb_cache_pkg::HTRANS_IDLE && !dn_resp.hready) |=>
            $stable(dn_req.haddr)
    ) else $error("downstream address changed during a wait state");

endmodule

`default_nettype wire

/* hdl/cache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_cache_cfg.svh"

module cache_data_store (
    input  wire                       upstream_intf,
    input  wire                       rst,
    input  wire ahb_cache_pkg::pend_t pend,
    input  wire                       fill_we,
    input  wire [1:0]                 fill_word,
    input  wire [31:0]                fill_data,
    output logic [31:0]               rd_word
);

    // Each line is an array of words so one word can be written at a time.
    logic [`LINE_WORDS-1:0][31:0] line_q [ahb_cache_pkg::LINES];

    logic [ahb_cache_pkg::IDX_W-1:0] idx;

    assign idx = pend.addr.f.index;

    // ------------------------------
    // Word write port
    // ------------------------------
    // Refill beats arrive in wrapped order, write hits at the pending offset.
    // Both select the word through fill_word.
    always_ff @(posedge upstream_intf) begin
        if (fill_we) begin
            line_q[idx][fill_word] <= fill_data;
        end
    end

    // ------------------------------
    // Word read port
    // ------------------------------
    assign rd_word = line_q[idx][pend.addr.f.word_off];  // Read is asynchronous.

    // The line index comes from pend, so a fill without a pending transfer
    // would write an arbitrary line.
    a_fill_has_pend: assert property (
        @(posedge upstream_intf) disable iff (rst)
        fill_we |-> pend.valid
    ) else $error("line write without a pending transfer");

endmodule

`default_nettype wire

/* hdl/cache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store (
    input  wire                        upstream_intf,
    input  wire                        rst,
    input  wire ahb_cache_pkg::pend_t  pend,
    input  wire                        tag_set,
    output logic                       hit
);

    logic [ahb_cache_pkg::LINES-1:0] valid_q;
    logic [ahb_cache_pkg::TAG_W-1:0] tag_q [ahb_cache_pkg::LINES];

    logic [ahb_cache_pkg::IDX_W-1:0] idx;
    logic [ahb_cache_pkg::TAG_W-1:0] tag;

    assign idx = pend.addr.f.index;
    assign tag = pend.addr.f.tag;

    // ------------------------------
    // Valid bits
    // ------------------------------
    always_ff @(posedge upstream_intf) begin
        if (rst) begin
            valid_q <= '0;
        end else if (tag_set) begin
            valid_q[idx] <= 1'b1;  // Line is usable from the next cycle.
        end
    end

    // ------------------------------
    // Tag array
    // ------------------------------
    always_ff @(posedge upstream_intf) begin
        if (tag_set) begin
            tag_q[idx] <= tag;
        end
    end

    // Direct mapped, so one compare decides it.
    assign hit = pend.valid && valid_q[idx] && (tag_q[idx] == tag);

    // A refill is only started on a miss, and the pending transfer cannot
    // change while the upstream side is stalled.
    a_no_set_on_hit: assert property (
        @(posedge upstream_intf) disable iff (rst)
        tag_set |-> !hit
    ) else $error("tag written for a line that already hits");

endmodule

`default_nettype wire

/* hdl/ahb_addr_phase.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_addr_phase (
    input  wire                       upstream_intf,
    input  wire                       rst,
    input  wire ahb_cache_pkg::ahb_req_t up_req,
    input  wire                       accept,
    output ahb_cache_pkg::pend_t      pend
);

    logic start;

    // Only NONSEQ and SEQ carry a transfer, IDLE and BUSY leave nothing to do.
    assign start = (up_req.htrans == ahb_cache_pkg::HTRANS_NONSEQ) ||
                   (up_req.htrans == ahb_cache_pkg::HTRANS_SEQ);

    // ------------------------------
    // Address phase register
    // ------------------------------
    // accept is the local hready. When it is high the current data phase ends
    // and whatever sits on the bus becomes the next pending transfer.
    always_ff @(posedge upstream_intf) begin
        if (rst) begin
            pend.valid <= 1'b0;
        end else if (accept) begin
            pend.addr.raw <= up_req.haddr;
            pend.write    <= up_req.hwrite;
            pend.valid    <= start;  // Drops to zero when the bus goes idle.
        end
    end

    // The line store is organised in words, so narrower or unaligned
    // transfers from the master would land in the wrong place.
    a_word_size: assert property (
        @(posedge upstream_intf) disable iff (rst)
        (accept && start) |->
            (up_req.hsize == ahb_cache_pkg::HSIZE_WORD) && (up_req.haddr[1:0] == 2'b00)
    ) else $error("upstream transfer is not an aligned word");

endmodule

`default_nettype wire

/* hdl/ahb_cache_pkg.sv */
`default_nettype none

`include "ahb_cache_cfg.svh"

package ahb_cache_pkg;

    // Geometry derived from the cfg macros.
    localparam int LINE_BYTES = `LINE_WORDS * 4;
    localparam int LINES      = `CACHE_BYTES / LINE_BYTES;
    localparam int IDX_W      = $clog2(LINES);
    localparam int OFF_W      = $clog2(`LINE_WORDS);
    localparam int TAG_W      = `ADDR_W - IDX_W - OFF_W - 2;

    localparam logic [2:0] HSIZE_WORD = 3'b010;
    localparam logic       HRESP_OKAY = 1'b0;

    // ------------------------------
    // AHB encodings and bundles
    // ------------------------------
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } ahb_trans_e;

    typedef enum logic [2:0] {
        HBURST_SINGLE = 3'b000,
        HBURST_WRAP4  = 3'b010
    } ahb_burst_e;

    typedef struct packed {
        logic [`ADDR_W-1:0] haddr;
        ahb_trans_e         htrans;
        logic               hwrite;
        logic [2:0]         hsize;
        ahb_burst_e         hburst;
        logic [31:0]        hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_resp_t;

    // ------------------------------
    // Cache address views
    // ------------------------------
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] index;
        logic [OFF_W-1:0] word_off;
        logic [1:0]       byte_off;
    } cache_addr_fields_t;

    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        cache_addr_fields_t f;
    } cache_addr_t;

    // Upstream transfer held for its data phase.
    typedef struct packed {
        cache_addr_t addr;
        logic        write;
        logic        valid;
    } pend_t;

endpackage

`default_nettype wire

/* include/ahb_cache_cfg.svh */
`ifndef AHB_CACHE_CFG_SVH
`define AHB_CACHE_CFG_SVH

// Total cache capacity in bytes, 1024 gives 64 lines.
`define CACHE_BYTES 1024

// Words per line. The downstream refill is a WRAP4 burst, so this stays at 4.
`define LINE_WORDS 4

// Address width on both AHB ports.
`define ADDR_W 32

`endif
